// File: logic/hl2_ctrl_pkg.sv
// shared widths, command addresses, frame and status constants and the response type
`default_nettype none

package hl2_ctrl_pkg;

  //////////////////////////////////////////////////////////////////////
  // widths

  // stream byte and command fields
  localparam int BYTE_W     = 8;
  localparam int CMD_ADDR_W = 6;
  localparam int CMD_DATA_W = 32;

  // five bytes per frame in both directions
  localparam int FRAME_BYTES = 5;
  localparam int FRAME_CNT_W = $clog2(FRAME_BYTES);

  typedef logic [CMD_ADDR_W-1:0] cmd_addr_t;
  typedef logic [CMD_DATA_W-1:0] cmd_data_t;

  //////////////////////////////////////////////////////////////////////
  // command address map

  // bit 0 is run
  localparam cmd_addr_t ADDR_GENERAL   = 6'h00;
  localparam cmd_addr_t ADDR_TX_FREQ   = 6'h01;
  localparam cmd_addr_t ADDR_RX_FREQ   = 6'h02;
  // low 6 bits are the gain
  localparam cmd_addr_t ADDR_LNA_GAIN  = 6'h0a;
  // bit 0 run LED enable, bit 1 external PA keying enable
  localparam cmd_addr_t ADDR_IO_CONFIG = 6'h39;
  // tag of the periodic status frames
  localparam cmd_addr_t ADDR_STATUS    = 6'h3f;

  // clk_ctrl cycles between status frames while running
  localparam int STATUS_PERIOD = 200;
  localparam int STATUS_CNT_W  = $clog2(STATUS_PERIOD);

  // one upstream reply, address above data
  typedef struct packed {
    cmd_addr_t addr;
    cmd_data_t data;
  } resp_t;

endpackage

`default_nettype wire

// File: logic/cmd_frame_parser.sv
// command frame parser with byte counter, header and data capture and command strobe
`default_nettype none

module cmd_frame_parser (
  input  logic                            clk_ctrl,
  input  logic                            reset_i,
  input  logic                            rx_valid_i,
  input  logic                            rx_sof_i,
  input  logic [hl2_ctrl_pkg::BYTE_W-1:0] rx_data_i,
  output logic                            cmd_valid_o,
  output hl2_ctrl_pkg::cmd_addr_t         cmd_addr_o,
  output hl2_ctrl_pkg::cmd_data_t         cmd_data_o,
  output logic                            cmd_mox_o,
  output logic                            cmd_resp_rqst_o
);

  import hl2_ctrl_pkg::*;

  // zero means no frame in progress
  logic [FRAME_CNT_W-1:0] byte_cnt;
  logic [BYTE_W-1:0]      hdr_byte;
  cmd_data_t              data_sr;

  logic last_byte;

  assign last_byte = (byte_cnt == FRAME_CNT_W'(FRAME_BYTES - 1));

  //////////////////////////////////////////////////////////////////////
  // byte collection

  always_ff @(posedge clk_ctrl) begin
    if (reset_i) begin
      byte_cnt    <= '0;
      hdr_byte    <= '0;
      data_sr     <= '0;
      cmd_valid_o <= 1'b0;
    end else begin
      cmd_valid_o <= 1'b0;
      if (rx_valid_i) begin
        if (rx_sof_i) begin
          // start of frame always restarts the count
          hdr_byte <= rx_data_i;
          byte_cnt <= FRAME_CNT_W'(1);
        end else if (byte_cnt != '0) begin
          // data bytes arrive msb first
          data_sr <= {data_sr[CMD_DATA_W-BYTE_W-1:0], rx_data_i};
          if (last_byte) begin
            byte_cnt    <= '0;
            cmd_valid_o <= 1'b1;
          end else begin
            byte_cnt <= byte_cnt + FRAME_CNT_W'(1);
          end
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // header fields

  // rqst in bit 7, address in 6..1, mox in bit 0
  assign cmd_resp_rqst_o = hdr_byte[7];
  assign cmd_addr_o      = hdr_byte[CMD_ADDR_W:1];
  assign cmd_mox_o       = hdr_byte[0];
  assign cmd_data_o      = data_sr;

endmodule

`default_nettype wire

// File: logic/radio_regs.sv
// radio register peer with run and MOX state, tx_on derivation and one response slot
`default_nettype none

module radio_regs (
  input  logic                    clk_ctrl,
  input  logic                    reset_i,
  input  logic                    cmd_valid_i,
  input  hl2_ctrl_pkg::cmd_addr_t cmd_addr_i,
  input  hl2_ctrl_pkg::cmd_data_t cmd_data_i,
  input  logic                    cmd_mox_i,
  input  logic                    cmd_resp_rqst_i,
  input  logic                    io_tx_inhibit_i,
  input  logic                    resp_grant_i,
  output logic                    resp_req_o,
  output hl2_ctrl_pkg::resp_t     resp_o,
  output logic                    run_o,
  output logic                    tx_on_o,
  output hl2_ctrl_pkg::cmd_data_t tx_freq_o,
  output hl2_ctrl_pkg::cmd_data_t rx_freq_o,
  output logic [5:0]              lna_gain_o
);

  import hl2_ctrl_pkg::*;

  logic own_addr;
  logic run_d;
  logic mox_q;
  logic mox_d;

  assign own_addr = cmd_addr_i inside {ADDR_GENERAL, ADDR_TX_FREQ, ADDR_RX_FREQ, ADDR_LNA_GAIN};

  // next run and mox, so tx_on lines up with run_o
  always_comb begin
    run_d = run_o;
    mox_d = mox_q;
    if (cmd_valid_i) begin
      mox_d = cmd_mox_i;
      if (cmd_addr_i == ADDR_GENERAL) begin
        run_d = cmd_data_i[0];
      end
    end
  end

  always_ff @(posedge clk_ctrl) begin
    if (reset_i) begin
      run_o      <= 1'b0;
      mox_q      <= 1'b0;
      tx_on_o    <= 1'b0;
      tx_freq_o  <= '0;
      rx_freq_o  <= '0;
      lna_gain_o <= '0;
      resp_req_o <= 1'b0;
      resp_o     <= '0;
    end else begin
      run_o   <= run_d;
      mox_q   <= mox_d;
      tx_on_o <= run_d & mox_d & ~io_tx_inhibit_i;

      if (cmd_valid_i) begin
        case (cmd_addr_i)
          ADDR_TX_FREQ:  tx_freq_o  <= cmd_data_i;
          ADDR_RX_FREQ:  rx_freq_o  <= cmd_data_i;
          ADDR_LNA_GAIN: lna_gain_o <= cmd_data_i[5:0];
          default: ;
        endcase
      end

      // single slot, requests while pending are lost
      if (resp_req_o && resp_grant_i) begin
        resp_req_o <= 1'b0;
      end else if (!resp_req_o && cmd_valid_i && cmd_resp_rqst_i && own_addr) begin
        resp_req_o  <= 1'b1;
        resp_o.addr <= cmd_addr_i;
        resp_o.data <= cmd_data_i;
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/io_ctrl.sv
// I/O register peer with LED and PA outputs, sticky receive status and periodic status requests
`default_nettype none

module io_ctrl (
  input  logic                    clk_ctrl,
  input  logic                    reset_i,
  input  logic                    cmd_valid_i,
  input  hl2_ctrl_pkg::cmd_addr_t cmd_addr_i,
  input  hl2_ctrl_pkg::cmd_data_t cmd_data_i,
  input  logic                    cmd_resp_rqst_i,
  input  logic                    run_i,
  input  logic                    tx_on_i,
  input  logic                    rxclip_i,
  input  logic                    rxgoodlvl_i,
  input  logic                    resp_grant_i,
  output logic                    resp_req_o,
  output hl2_ctrl_pkg::resp_t     resp_o,
  output logic                    io_led_run_o,
  output logic                    io_led_tx_o,
  output logic                    pa_exttr_o
);

  import hl2_ctrl_pkg::*;

  logic [1:0]              io_cfg;
  logic                    clip_sticky;
  logic                    good_sticky;
  logic                    status_pend;
  logic [STATUS_CNT_W-1:0] period_cnt;

  logic cfg_hit;
  logic status_due;
  logic status_clr;

  assign cfg_hit    = cmd_valid_i && (cmd_addr_i == ADDR_IO_CONFIG);
  assign status_due = run_i && (period_cnt == STATUS_CNT_W'(STATUS_PERIOD - 1));
  assign status_clr = resp_req_o && resp_grant_i && status_pend;

  // front panel and PA keying
  assign io_led_run_o = run_i & io_cfg[0];
  assign io_led_tx_o  = tx_on_i;
  assign pa_exttr_o   = tx_on_i & io_cfg[1];

  //////////////////////////////////////////////////////////////////////
  // config, status and response slot

  always_ff @(posedge clk_ctrl) begin
    if (reset_i) begin
      io_cfg      <= '0;
      clip_sticky <= 1'b0;
      good_sticky <= 1'b0;
      status_pend <= 1'b0;
      period_cnt  <= '0;
      resp_req_o  <= 1'b0;
      resp_o      <= '0;
    end else begin
      if (cfg_hit) begin
        io_cfg <= cmd_data_i[1:0];
      end

      // inputs win over the clear on the same cycle
      clip_sticky <= (clip_sticky & ~status_clr) | rxclip_i;
      good_sticky <= (good_sticky & ~status_clr) | rxgoodlvl_i;

      // free runs only while run is set
      if (!run_i || status_due) begin
        period_cnt <= '0;
      end else begin
        period_cnt <= period_cnt + STATUS_CNT_W'(1);
      end

      // command reply first, a status due on the same cycle is skipped
      if (resp_req_o && resp_grant_i) begin
        resp_req_o  <= 1'b0;
        status_pend <= 1'b0;
      end else if (!resp_req_o) begin
        if (cfg_hit && cmd_resp_rqst_i) begin
          resp_req_o  <= 1'b1;
          status_pend <= 1'b0;
          resp_o.addr <= ADDR_IO_CONFIG;
          resp_o.data <= cmd_data_i;
        end else if (status_due) begin
          resp_req_o  <= 1'b1;
          status_pend <= 1'b1;
          resp_o.addr <= ADDR_STATUS;
          resp_o.data <= {{(CMD_DATA_W-2){1'b0}}, clip_sticky, good_sticky};
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/response_arbiter.sv
// round-robin response arbiter and five-byte frame serializer with ready back-pressure
`default_nettype none

module response_arbiter (
  input  logic                            clk_ctrl,
  input  logic                            reset_i,
  input  logic                            req_radio_i,
  input  hl2_ctrl_pkg::resp_t             resp_radio_i,
  input  logic                            req_io_i,
  input  hl2_ctrl_pkg::resp_t             resp_io_i,
  output logic                            grant_radio_o,
  output logic                            grant_io_o,
  input  logic                            tx_ready_i,
  output logic                            tx_valid_o,
  output logic [hl2_ctrl_pkg::BYTE_W-1:0] tx_data_o,
  output logic                            tx_last_o
);

  import hl2_ctrl_pkg::*;

  logic                          busy;
  logic                          last_io;
  logic [FRAME_CNT_W-1:0]        byte_idx;
  logic [FRAME_BYTES*BYTE_W-1:0] frame_sr;

  logic  pick_io;
  logic  byte_taken;
  resp_t resp_sel;

  //////////////////////////////////////////////////////////////////////
  // arbitration

  // on a tie the peer not served last goes first
  assign pick_io       = req_io_i & (~req_radio_i | ~last_io);
  assign grant_io_o    = ~busy & pick_io;
  assign grant_radio_o = ~busy & req_radio_i & ~pick_io;
  assign resp_sel      = grant_io_o ? resp_io_i : resp_radio_i;

  //////////////////////////////////////////////////////////////////////
  // serializer

  assign byte_taken = tx_valid_o & tx_ready_i;
  assign tx_valid_o = busy;
  assign tx_data_o  = frame_sr[FRAME_BYTES*BYTE_W-1 -: BYTE_W];
  assign tx_last_o  = busy && (byte_idx == FRAME_CNT_W'(FRAME_BYTES - 1));

  always_ff @(posedge clk_ctrl) begin
    if (reset_i) begin
      busy     <= 1'b0;
      last_io  <= 1'b0;
      byte_idx <= '0;
      frame_sr <= '0;
    end else if (!busy) begin
      if (grant_radio_o || grant_io_o) begin
        busy     <= 1'b1;
        last_io  <= grant_io_o;
        byte_idx <= '0;
        // address byte padded with zeros, then data msb first
        frame_sr <= {{(BYTE_W-CMD_ADDR_W){1'b0}}, resp_sel.addr, resp_sel.data};
      end
    end else if (byte_taken) begin
      if (tx_last_o) begin
        busy     <= 1'b0;
        byte_idx <= '0;
      end else begin
        byte_idx <= byte_idx + FRAME_CNT_W'(1);
        frame_sr <= {frame_sr[(FRAME_BYTES-1)*BYTE_W-1:0], {BYTE_W{1'b0}}};
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/hl2_ctrl_core.sv
// control core top with parser, radio and I/O register peers and the response arbiter
`default_nettype none

module hl2_ctrl_core (
  input  logic                            clk_ctrl,
  input  logic                            reset_i,
  input  logic                            rx_valid_i,
  input  logic                            rx_sof_i,
  input  logic [hl2_ctrl_pkg::BYTE_W-1:0] rx_data_i,
  input  logic                            io_tx_inhibit_i,
  input  logic                            rxclip_i,
  input  logic                            rxgoodlvl_i,
  input  logic                            tx_ready_i,
  output logic                            tx_valid_o,
  output logic [hl2_ctrl_pkg::BYTE_W-1:0] tx_data_o,
  output logic                            tx_last_o,
  output logic                            tx_on_o,
  output hl2_ctrl_pkg::cmd_data_t         tx_freq_o,
  output hl2_ctrl_pkg::cmd_data_t         rx_freq_o,
  output logic [5:0]                      lna_gain_o,
  output logic                            io_led_run_o,
  output logic                            io_led_tx_o,
  output logic                            pa_exttr_o
);

  import hl2_ctrl_pkg::*;

  // command bus to both peers
  logic      cmd_valid;
  cmd_addr_t cmd_addr;
  cmd_data_t cmd_data;
  logic      cmd_mox;
  logic      cmd_resp_rqst;

  logic      run;

  // response channel
  logic      req_radio;
  logic      req_io;
  logic      grant_radio;
  logic      grant_io;
  resp_t     resp_radio;
  resp_t     resp_io;

  //////////////////////////////////////////////////////////////////////
  // downstream commands

  cmd_frame_parser parser_i (
    .clk_ctrl        (clk_ctrl     ),
    .reset_i         (reset_i      ),
    .rx_valid_i      (rx_valid_i   ),
    .rx_sof_i        (rx_sof_i     ),
    .rx_data_i       (rx_data_i    ),
    .cmd_valid_o     (cmd_valid    ),
    .cmd_addr_o      (cmd_addr     ),
    .cmd_data_o      (cmd_data     ),
    .cmd_mox_o       (cmd_mox      ),
    .cmd_resp_rqst_o (cmd_resp_rqst)
  );

  //////////////////////////////////////////////////////////////////////
  // register peers

  radio_regs radio_regs_i (
    .clk_ctrl        (clk_ctrl       ),
    .reset_i         (reset_i        ),
    .cmd_valid_i     (cmd_valid      ),
    .cmd_addr_i      (cmd_addr       ),
    .cmd_data_i      (cmd_data       ),
    .cmd_mox_i       (cmd_mox        ),
    .cmd_resp_rqst_i (cmd_resp_rqst  ),
    .io_tx_inhibit_i (io_tx_inhibit_i),
    .resp_grant_i    (grant_radio    ),
    .resp_req_o      (req_radio      ),
    .resp_o          (resp_radio     ),
    .run_o           (run            ),
    .tx_on_o         (tx_on_o        ),
    .tx_freq_o       (tx_freq_o      ),
    .rx_freq_o       (rx_freq_o      ),
    .lna_gain_o      (lna_gain_o     )
  );

  io_ctrl io_ctrl_i (
    .clk_ctrl        (clk_ctrl     ),
    .reset_i         (reset_i      ),
    .cmd_valid_i     (cmd_valid    ),
    .cmd_addr_i      (cmd_addr     ),
    .cmd_data_i      (cmd_data     ),
    .cmd_resp_rqst_i (cmd_resp_rqst),
    .run_i           (run          ),
    .tx_on_i         (tx_on_o      ),
    .rxclip_i        (rxclip_i     ),
    .rxgoodlvl_i     (rxgoodlvl_i  ),
    .resp_grant_i    (grant_io     ),
    .resp_req_o      (req_io       ),
    .resp_o          (resp_io      ),
    .io_led_run_o    (io_led_run_o ),
    .io_led_tx_o     (io_led_tx_o  ),
    .pa_exttr_o      (pa_exttr_o   )
  );

  //////////////////////////////////////////////////////////////////////
  // upstream replies

  response_arbiter arbiter_i (
    .clk_ctrl      (clk_ctrl   ),
    .reset_i       (reset_i    ),
    .req_radio_i   (req_radio  ),
    .resp_radio_i  (resp_radio ),
    .req_io_i      (req_io     ),
    .resp_io_i     (resp_io    ),
    .grant_radio_o (grant_radio),
    .grant_io_o    (grant_io   ),
    .tx_ready_i    (tx_ready_i ),
    .tx_valid_o    (tx_valid_o ),
    .tx_data_o     (tx_data_o  ),
    .tx_last_o     (tx_last_o  )
  );

endmodule

`default_nettype wire

// File: tb/hl2_ctrl_core_assert.sv
// bound checks for byte hold under back-pressure and exclusive grants on the response channel
`default_nettype none

module hl2_ctrl_core_assert (
  input logic                            clk_ctrl,
  input logic                            reset_i,
  input logic                            grant_radio_i,
  input logic                            grant_io_i,
  input logic                            tx_ready_i,
  input logic                            tx_valid_i,
  input logic [hl2_ctrl_pkg::BYTE_W-1:0] tx_data_i
);

  // flags read by the testbench
  logic hold_err  = 1'b0;
  logic grant_err = 1'b0;

  // a stalled byte stays on the channel
  stall_hold: assert property (@(posedge clk_ctrl) disable iff (reset_i)
    (tx_valid_i && !tx_ready_i) |=> (tx_valid_i && $stable(tx_data_i)))
  else begin
    $error("response byte or valid changed while stalled");
    hold_err = 1'b1;
  end

  grant_excl: assert property (@(posedge clk_ctrl) disable iff (reset_i)
    !(grant_radio_i && grant_io_i))
  else begin
    $error("both peers granted on the same cycle");
    grant_err = 1'b1;
  end

endmodule

bind response_arbiter hl2_ctrl_core_assert protocol_chk (
  .clk_ctrl      (clk_ctrl     ),
  .reset_i       (reset_i      ),
  .grant_radio_i (grant_radio_o),
  .grant_io_i    (grant_io_o   ),
  .tx_ready_i    (tx_ready_i   ),
  .tx_valid_i    (tx_valid_o   ),
  .tx_data_i     (tx_data_o    )
);

`default_nettype wire

// File: tb/hl2_ctrl_core_tb.sv
// testbench for the control core with random frames, reference model and response checks
`default_nettype none

module hl2_ctrl_core_tb;

  import hl2_ctrl_pkg::*;

  localparam int NUM_FRAMES = 80;
  localparam int WAIT_LIMIT = 4 * STATUS_PERIOD;
  // owned addresses first, then three that nobody decodes
  localparam cmd_addr_t ADDR_SET [8] = '{ADDR_GENERAL, ADDR_TX_FREQ, ADDR_RX_FREQ,
    ADDR_LNA_GAIN, ADDR_IO_CONFIG, 6'h05, 6'h1c, 6'h2e};

  logic        clk_ctrl;
  logic        reset_i;
  logic        rx_valid_i;
  logic        rx_sof_i;
  logic [7:0]  rx_data_i;
  logic        io_tx_inhibit_i;
  logic        rxclip_i;
  logic        rxgoodlvl_i;
  logic        tx_ready_i = 1'b1;
  logic        tx_valid_o;
  logic [7:0]  tx_data_o;
  logic        tx_last_o;
  logic        tx_on_o;
  cmd_data_t   tx_freq_o;
  cmd_data_t   rx_freq_o;
  logic [5:0]  lna_gain_o;
  logic        io_led_run_o;
  logic        io_led_tx_o;
  logic        pa_exttr_o;

  // reference model state
  logic        m_run;
  logic        m_mox;
  logic [1:0]  m_cfg;
  cmd_data_t   m_tx_freq;
  cmd_data_t   m_rx_freq;
  logic [5:0]  m_lna;

  // upstream collector
  logic [FRAME_BYTES*BYTE_W-1:0] shift_frame;
  int          byte_pos = 0;
  resp_t       got_q[$];
  logic        bind_err;

  hl2_ctrl_core uut (.*);

  assign bind_err = uut.arbiter_i.protocol_chk.hold_err | uut.arbiter_i.protocol_chk.grant_err;

  always #50 clk_ctrl = ~clk_ctrl;

  //////////////////////////////////////////////////////////////////////
  // failure reporting and checks

  task automatic stop_run(input string what);
    $display("%s", what);
    $display("Regression failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (exp === act)
    else stop_run($sformatf("** Error: %s expected 0x%08h actual 0x%08h", name, exp, act));
  endtask

  function automatic logic is_owned(input cmd_addr_t a);
    return a inside {ADDR_GENERAL, ADDR_TX_FREQ, ADDR_RX_FREQ, ADDR_LNA_GAIN, ADDR_IO_CONFIG};
  endfunction

  task automatic check_outputs;
    logic exp_tx_on;
    exp_tx_on = m_run & m_mox & ~io_tx_inhibit_i;
    check_val("tx_freq", m_tx_freq, tx_freq_o);
    check_val("rx_freq", m_rx_freq, rx_freq_o);
    check_val("lna_gain", 32'(m_lna), 32'(lna_gain_o));
    check_val("tx_on", 32'(exp_tx_on), 32'(tx_on_o));
    check_val("led_tx", 32'(exp_tx_on), 32'(io_led_tx_o));
    check_val("pa_exttr", 32'(exp_tx_on & m_cfg[1]), 32'(pa_exttr_o));
    check_val("led_run", 32'(m_run & m_cfg[0]), 32'(io_led_run_o));
  endtask

  //////////////////////////////////////////////////////////////////////
  // downstream stimulus

  task automatic send_byte(input logic sof, input logic [7:0] data);
    int gap;
    gap = $urandom_range(3);
    repeat (gap) @(negedge clk_ctrl);
    rx_valid_i = 1'b1;
    rx_sof_i   = sof;
    rx_data_i  = data;
    @(negedge clk_ctrl);
    rx_valid_i = 1'b0;
    rx_sof_i   = 1'b0;
  endtask

  // returns one cycle after the register update
  task automatic send_cmd(input cmd_addr_t addr, input cmd_data_t data, input logic mox,
                          input logic rqst);
    if ($urandom_range(7) == 0) begin
      // cut-off frame, discarded by the next start of frame
      send_byte(1'b1, 8'($urandom));
      send_byte(1'b0, 8'($urandom));
    end
    send_byte(1'b1, {rqst, addr, mox});
    for (int i = 3; i >= 0; i--) begin
      send_byte(1'b0, data[8*i +: 8]);
    end
    m_mox = mox;
    case (addr)
      ADDR_GENERAL:   m_run = data[0];
      ADDR_TX_FREQ:   m_tx_freq = data;
      ADDR_RX_FREQ:   m_rx_freq = data;
      ADDR_LNA_GAIN:  m_lna = data[5:0];
      ADDR_IO_CONFIG: m_cfg = data[1:0];
      default: ;
    endcase
    @(negedge clk_ctrl);
    check_outputs();
  endtask

  //////////////////////////////////////////////////////////////////////
  // upstream collection and waits

  // random back-pressure
  always @(negedge clk_ctrl) begin
    if (!reset_i) begin
      tx_ready_i = ($urandom_range(3) != 0);
    end
  end

  always @(posedge clk_ctrl) begin
    if (!reset_i && tx_valid_o && tx_ready_i) begin
      shift_frame = {shift_frame[(FRAME_BYTES-1)*BYTE_W-1:0], tx_data_o};
      check_val("tx_last", 32'(byte_pos == FRAME_BYTES - 1), 32'(tx_last_o));
      if (byte_pos == FRAME_BYTES - 1) begin
        check_val("pad bits", 32'd0, 32'(shift_frame[39:38]));
        got_q.push_back(resp_t'(shift_frame[37:0]));
        byte_pos = 0;
      end else begin
        byte_pos++;
      end
    end
  end

  always @(negedge clk_ctrl) begin
    assert (!bind_err) else stop_run("a bound protocol assertion fired on the response channel");
  end

  task automatic wait_frame(output resp_t r, input string what);
    int cnt;
    cnt = 0;
    while (got_q.size() == 0) begin
      @(negedge clk_ctrl);
      cnt++;
      if (cnt > WAIT_LIMIT) begin
        stop_run($sformatf("no %s frame arrived within %0d cycles", what, WAIT_LIMIT));
      end
    end
    r = got_q.pop_front();
  endtask

  task automatic wait_idle;
    int quiet;
    int cnt;
    quiet = 0;
    cnt = 0;
    while (quiet < 10) begin
      @(negedge clk_ctrl);
      quiet = tx_valid_o ? 0 : quiet + 1;
      cnt++;
      if (cnt > WAIT_LIMIT) begin
        stop_run("the response channel never went idle");
      end
    end
  endtask

  task automatic expect_quiet(input int cycles);
    repeat (cycles) begin
      @(negedge clk_ctrl);
      check_val("no frame", 32'd0, 32'(tx_valid_o));
    end
  endtask

  // skips stale frames, checks the flags of the last one
  task automatic check_status(input int frames, input cmd_data_t exp_data);
    resp_t r;
    for (int k = 0; k < frames; k++) begin
      wait_frame(r, "status");
      check_val("status addr", 32'(ADDR_STATUS), 32'(r.addr));
    end
    check_val("status flags", exp_data, r.data);
  endtask

  //////////////////////////////////////////////////////////////////////
  // test sequence

  initial begin
    resp_t     r;
    cmd_addr_t addr;
    cmd_data_t data;
    logic      mox;
    logic      rqst;
    void'($urandom(55));
    clk_ctrl        = 1'b0;
    reset_i         = 1'b1;
    rx_valid_i      = 1'b0;
    rx_sof_i        = 1'b0;
    rx_data_i       = '0;
    io_tx_inhibit_i = 1'b0;
    rxclip_i        = 1'b0;
    rxgoodlvl_i     = 1'b0;
    {m_run, m_mox, m_cfg, m_tx_freq, m_rx_freq, m_lna} = '0;
    repeat (4) @(negedge clk_ctrl);
    reset_i = 1'b0;
    @(negedge clk_ctrl);
    check_outputs();
    check_val("tx_valid after reset", 32'd0, 32'(tx_valid_o));
    check_val("tx_last after reset", 32'd0, 32'(tx_last_o));

    // register writes and command responses, run held off
    for (int n = 0; n < NUM_FRAMES; n++) begin
      addr = ADDR_SET[$urandom_range(7)];
      data = $urandom;
      if (addr == ADDR_GENERAL) data[0] = 1'b0;
      mox  = 1'($urandom_range(1));
      rqst = 1'($urandom_range(1));
      send_cmd(addr, data, mox, rqst);
      if (rqst && is_owned(addr)) begin
        wait_frame(r, "command response");
        check_val("resp addr", 32'(addr), 32'(r.addr));
        check_val("resp data", data, r.data);
      end else begin
        expect_quiet(12);
      end
    end

    // transmit enable against run, mox, inhibit and PA enable
    for (int n = 0; n < 40; n++) begin
      case ($urandom_range(2))
        0: send_cmd(ADDR_GENERAL, 32'($urandom_range(1)), 1'($urandom_range(1)), 1'b0);
        1: send_cmd(ADDR_IO_CONFIG, 32'($urandom_range(3)), 1'($urandom_range(1)), 1'b0);
        default: begin
          io_tx_inhibit_i = ~io_tx_inhibit_i;
          @(negedge clk_ctrl);
          check_outputs();
        end
      endcase
    end

    // status frames while running
    io_tx_inhibit_i = 1'b0;
    send_cmd(ADDR_GENERAL, 32'd1, 1'b0, 1'b0);
    rxgoodlvl_i = 1'b1;
    rxclip_i    = 1'b1;
    got_q.delete();
    check_status(2, 32'd3);
    rxclip_i = 1'b0;
    got_q.delete();
    check_status(3, 32'd1);

    // run cleared, channel stays silent
    send_cmd(ADDR_GENERAL, 32'd0, 1'b0, 1'b0);
    wait_idle();
    expect_quiet(3 * STATUS_PERIOD);

    if (bind_err) begin
      stop_run("a bound protocol assertion fired on the response channel");
    end else begin
      $display("Regression passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: hl2_ctrl.f
logic/hl2_ctrl_pkg.sv
logic/cmd_frame_parser.sv
logic/radio_regs.sv
logic/io_ctrl.sv
logic/response_arbiter.sv
logic/hl2_ctrl_core.sv
tb/hl2_ctrl_core_assert.sv
tb/hl2_ctrl_core_tb.sv

// File: Makefile
# Verilator lint, simulation and clean for the control core

VERILATOR  ?= verilator
FILELIST   := hl2_ctrl.f
TB_TOP     := hl2_ctrl_core_tb
RTL_TOP    := hl2_ctrl_core
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -Wall -Wno-fatal
SIM_ARGS   := +verilator+error+limit+100
OBJ_DIR    := obj_dir
SIM_BIN    := $(OBJ_DIR)/V$(TB_TOP)
LOG        := sim.log
FAIL_MSG   := Regression failed
PASS_MSG   := Regression passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

$(SIM_BIN): $(shell cat $(FILELIST)) $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(SIM_BIN)
	-$(SIM_BIN) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
